// File: hw/uart_cmd_pkg.sv
package uart_cmd_pkg;

    // ====================
    // widths and modes
    // ====================
    localparam int byte_w = 8;

    // mode_sel code for matrix entry
    localparam logic [1:0] mode_input = 2'd1;

    // ====================
    // character codes
    // ====================
    localparam logic [byte_w-1:0] ch_space = 8'h20;
    localparam logic [byte_w-1:0] ch_cr    = 8'h0d;
    localparam logic [byte_w-1:0] ch_lf    = 8'h0a;
    localparam logic [byte_w-1:0] ch_minus = 8'h2d;
    localparam logic [byte_w-1:0] ch_0     = 8'h30;
    localparam logic [byte_w-1:0] ch_9     = 8'h39;

    // keyword letters, upper case only
    localparam logic [byte_w-1:0] ch_a = 8'h41;
    localparam logic [byte_w-1:0] ch_c = 8'h43;
    localparam logic [byte_w-1:0] ch_e = 8'h45;
    localparam logic [byte_w-1:0] ch_f = 8'h46;
    localparam logic [byte_w-1:0] ch_g = 8'h47;
    localparam logic [byte_w-1:0] ch_i = 8'h49;
    localparam logic [byte_w-1:0] ch_l = 8'h4c;
    localparam logic [byte_w-1:0] ch_m = 8'h4d;
    localparam logic [byte_w-1:0] ch_n = 8'h4e;
    localparam logic [byte_w-1:0] ch_o = 8'h4f;
    localparam logic [byte_w-1:0] ch_r = 8'h52;
    localparam logic [byte_w-1:0] ch_s = 8'h53;
    localparam logic [byte_w-1:0] ch_t = 8'h54;
    localparam logic [byte_w-1:0] ch_u = 8'h55;
    localparam logic [byte_w-1:0] ch_x = 8'h58;

    // ====================
    // types
    // ====================
    typedef enum logic [3:0] {
        st_idle, st_dim_m, st_dim_n, st_elem, st_id_a, st_id_b,
        st_cfg_val1, st_cfg_val2, st_done
    } parse_state_t;

    typedef enum logic [2:0] {
        cfg_max    = 3'd0,
        cfg_range  = 3'd1,
        cfg_count  = 3'd2,
        cfg_scalar = 3'd4
    } cfg_kind_t;

endpackage

// File: hw/decimal_accum.sv
`timescale 1ns/1ps

module decimal_accum import uart_cmd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [byte_w-1:0]        rx_data,
    input  logic                     rx_valid,
    input  logic                     clear,
    input  logic                     sign_en,
    output logic signed [byte_w-1:0] num_value,
    output logic                     num_end,
    output logic                     first_digit
);

    logic [byte_w-1:0] acc;
    logic [byte_w-1:0] digit_val;
    logic              building;
    logic              negative;
    logic              is_digit;
    logic              is_delim;
    logic              is_minus;

    // byte classes
    assign is_digit  = (rx_data >= ch_0) && (rx_data <= ch_9);
    assign is_delim  = (rx_data == ch_space) || (rx_data == ch_cr) || (rx_data == ch_lf);
    assign is_minus  = (rx_data == ch_minus);
    assign digit_val = rx_data - ch_0;

    // a digit under clear still opens a fresh number
    assign first_digit = rx_valid && is_digit && (!building || clear);
    assign num_end     = rx_valid && is_delim && building && !clear;
    assign num_value   = negative ? -$signed(acc) : $signed(acc);

    // value*10 + digit, wraps at the byte width
    always_ff @(posedge clk) begin
        if (rx_valid && is_digit) begin
            if (first_digit) begin
                acc <= digit_val;
            end else begin
                acc <= acc * 8'd10 + digit_val;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            building <= 1'b0;
            negative <= 1'b0;
        end else if (rx_valid && is_digit) begin
            building <= 1'b1;
            if (clear) begin
                negative <= 1'b0;
            end
        end else if (clear || num_end) begin
            building <= 1'b0;
            negative <= 1'b0;
        end else if (rx_valid && is_minus && sign_en && !building) begin
            // minus only counts before the first digit
            negative <= 1'b1;
        end
    end

endmodule

// File: hw/config_keyword_detect.sv
`timescale 1ns/1ps

module config_keyword_detect import uart_cmd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [byte_w-1:0] rx_data,
    input  logic              rx_valid,
    input  logic              scan_en,
    output logic              kw_hit,
    output cfg_kind_t         kw_kind
);

    // ====================
    // keyword patterns
    // ====================
    localparam logic [7*byte_w-1:0] kw_config = {ch_c, ch_o, ch_n, ch_f, ch_i, ch_g, ch_space};
    localparam logic [3*byte_w-1:0] kw_max    = {ch_m, ch_a, ch_x};
    localparam logic [5*byte_w-1:0] kw_range  = {ch_r, ch_a, ch_n, ch_g, ch_e};
    localparam logic [5*byte_w-1:0] kw_count  = {ch_c, ch_o, ch_u, ch_n, ch_t};
    localparam logic [6*byte_w-1:0] kw_scalar = {ch_s, ch_c, ch_a, ch_l, ch_a, ch_r};

    logic [7*byte_w-1:0] window;
    logic [7*byte_w-1:0] window_next;
    logic [6*byte_w-1:0] sub_word;
    logic [6*byte_w-1:0] sub_next;
    logic [2:0]          sub_len;
    logic                armed;
    logic                accept;
    logic                is_delim;

    assign accept      = rx_valid && scan_en;
    assign is_delim    = (rx_data == ch_space) || (rx_data == ch_cr) || (rx_data == ch_lf);
    assign window_next = {window[6*byte_w-1:0], rx_data};
    assign sub_next    = {sub_word[5*byte_w-1:0], rx_data};

    // sub-word shift register, sub_len says how much of it is live
    always_ff @(posedge clk) begin
        if (accept) begin
            sub_word <= sub_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window  <= '0;
            armed   <= 1'b0;
            sub_len <= 3'd0;
            kw_hit  <= 1'b0;
            kw_kind <= cfg_max;
        end else begin
            kw_hit <= 1'b0;
            if (!scan_en) begin
                armed <= 1'b0;
            end else if (rx_valid) begin
                window <= window_next;
                if (window_next == kw_config) begin
                    armed   <= 1'b1;
                    sub_len <= 3'd0;
                end else if (armed) begin
                    if (is_delim || sub_len == 3'd6) begin
                        armed <= 1'b0;
                    end else begin
                        sub_len <= sub_len + 3'd1;
                        // match only when the sub-word has exactly the keyword length
                        if (sub_len == 3'd2 && sub_next[3*byte_w-1:0] == kw_max) begin
                            kw_hit  <= 1'b1;
                            kw_kind <= cfg_max;
                            armed   <= 1'b0;
                        end else if (sub_len == 3'd4 && sub_next[5*byte_w-1:0] == kw_range) begin
                            kw_hit  <= 1'b1;
                            kw_kind <= cfg_range;
                            armed   <= 1'b0;
                        end else if (sub_len == 3'd4 && sub_next[5*byte_w-1:0] == kw_count) begin
                            kw_hit  <= 1'b1;
                            kw_kind <= cfg_count;
                            armed   <= 1'b0;
                        end else if (sub_len == 3'd5 && sub_next == kw_scalar) begin
                            kw_hit  <= 1'b1;
                            kw_kind <= cfg_scalar;
                            armed   <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hw/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer import uart_cmd_pkg::*; #(
    parameter int dim_w = 3,
    parameter int id_w  = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rx_valid,
    input  logic [1:0]               mode_sel,
    input  logic                     in_operand_select,
    input  logic signed [byte_w-1:0] num_value,
    input  logic                     num_end,
    input  logic                     first_digit,
    input  logic                     kw_hit,
    input  cfg_kind_t                kw_kind,
    output logic                     clear,
    output logic                     sign_en,
    output logic                     scan_en,
    output logic [dim_w-1:0]         dim_m,
    output logic [dim_w-1:0]         dim_n,
    output logic [byte_w-1:0]        elem_data,
    output logic                     write_en,
    output logic                     data_ready,
    output logic [id_w-1:0]          user_id_a,
    output logic [id_w-1:0]          user_id_b,
    output logic                     user_input_valid,
    output logic                     config_valid,
    output cfg_kind_t                config_type,
    output logic signed [byte_w-1:0] config_value1,
    output logic signed [byte_w-1:0] config_value2
);

    parse_state_t           state;
    parse_state_t           next_state;
    cfg_kind_t              cmd_kind;
    logic                   matrix_cmd;
    logic [2*dim_w-1:0]     elem_total;
    logic [2*dim_w-1:0]     elem_cnt;
    logic                   last_elem;

    assign elem_total = dim_m * dim_n;
    assign last_elem  = (elem_cnt == elem_total - 1'b1);

    // accumulator and keyword control
    assign clear   = (state == st_idle) || (state == st_done);
    assign sign_en = (state == st_cfg_val1) || (state == st_cfg_val2);
    assign scan_en = (state == st_idle);

    // ====================
    // next state
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (kw_hit) begin
                    next_state = st_cfg_val1;
                end else if (in_operand_select) begin
                    next_state = st_id_a;
                end else if (mode_sel == mode_input && rx_valid && first_digit) begin
                    next_state = st_dim_m;
                end
            end
            st_dim_m: if (num_end) next_state = st_dim_n;
            st_dim_n: if (num_end) next_state = st_elem;
            st_elem: begin
                // empty matrix skips straight to completion
                if (elem_total == '0) begin
                    next_state = st_done;
                end else if (num_end && last_elem) begin
                    next_state = st_done;
                end
            end
            st_id_a: if (num_end) next_state = st_id_b;
            st_id_b: if (num_end) next_state = st_done;
            st_cfg_val1: begin
                if (num_end) begin
                    next_state = (cmd_kind == cfg_range) ? st_cfg_val2 : st_done;
                end
            end
            st_cfg_val2: if (num_end) next_state = st_done;
            st_done: next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // ====================
    // registered results
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_kind         <= cfg_max;
            matrix_cmd       <= 1'b0;
            elem_cnt         <= '0;
            dim_m            <= '0;
            dim_n            <= '0;
            elem_data        <= '0;
            write_en         <= 1'b0;
            data_ready       <= 1'b0;
            user_id_a        <= '0;
            user_id_b        <= '0;
            user_input_valid <= 1'b0;
            config_valid     <= 1'b0;
            config_type      <= cfg_max;
            config_value1    <= '0;
            config_value2    <= '0;
        end else begin
            write_en         <= 1'b0;
            data_ready       <= 1'b0;
            user_input_valid <= 1'b0;
            config_valid     <= 1'b0;
            case (state)
                st_idle: begin
                    elem_cnt   <= '0;
                    matrix_cmd <= 1'b0;
                    if (kw_hit) begin
                        cmd_kind <= kw_kind;
                    end
                end
                st_dim_m: begin
                    matrix_cmd <= 1'b1;
                    if (num_end) dim_m <= num_value[dim_w-1:0];
                end
                st_dim_n: if (num_end) dim_n <= num_value[dim_w-1:0];
                st_elem: begin
                    if (num_end && elem_total != '0) begin
                        elem_data <= $unsigned(num_value);
                        write_en  <= 1'b1;
                        elem_cnt  <= elem_cnt + 1'b1;
                    end
                end
                st_id_a: if (num_end) user_id_a <= num_value[id_w-1:0];
                st_id_b: begin
                    if (num_end) begin
                        user_id_b        <= num_value[id_w-1:0];
                        user_input_valid <= 1'b1;
                    end
                end
                st_cfg_val1: begin
                    if (num_end) begin
                        config_value1 <= num_value;
                        // range waits for its second value
                        if (cmd_kind != cfg_range) begin
                            config_type  <= cmd_kind;
                            config_valid <= 1'b1;
                        end
                    end
                end
                st_cfg_val2: begin
                    if (num_end) begin
                        config_value2 <= num_value;
                        config_type   <= cmd_kind;
                        config_valid  <= 1'b1;
                    end
                end
                st_done: data_ready <= matrix_cmd;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/uart_cmd_parser.sv
`timescale 1ns/1ps

module uart_cmd_parser import uart_cmd_pkg::*; #(
    parameter int dim_w = 3,
    parameter int id_w  = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [byte_w-1:0]        rx_data,
    input  logic                     rx_valid,
    input  logic [1:0]               mode_sel,
    input  logic                     in_operand_select,
    output logic [dim_w-1:0]         dim_m,
    output logic [dim_w-1:0]         dim_n,
    output logic [byte_w-1:0]        elem_data,
    output logic                     write_en,
    output logic                     data_ready,
    output logic [id_w-1:0]          user_id_a,
    output logic [id_w-1:0]          user_id_b,
    output logic                     user_input_valid,
    output logic                     config_valid,
    output cfg_kind_t                config_type,
    output logic signed [byte_w-1:0] config_value1,
    output logic signed [byte_w-1:0] config_value2
);

    // number path
    logic signed [byte_w-1:0] num_value;
    logic                     num_end;
    logic                     first_digit;
    logic                     clear;
    logic                     sign_en;

    // keyword path
    logic                     scan_en;
    logic                     kw_hit;
    cfg_kind_t                kw_kind;

    decimal_accum u_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .clear       (clear),
        .sign_en     (sign_en),
        .num_value   (num_value),
        .num_end     (num_end),
        .first_digit (first_digit)
    );

    config_keyword_detect u_kw (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .scan_en  (scan_en),
        .kw_hit   (kw_hit),
        .kw_kind  (kw_kind)
    );

    cmd_sequencer #(
        .dim_w (dim_w),
        .id_w  (id_w)
    ) u_seq (
        .clk               (clk),
        .rst_n             (rst_n),
        .rx_valid          (rx_valid),
        .mode_sel          (mode_sel),
        .in_operand_select (in_operand_select),
        .num_value         (num_value),
        .num_end           (num_end),
        .first_digit       (first_digit),
        .kw_hit            (kw_hit),
        .kw_kind           (kw_kind),
        .clear             (clear),
        .sign_en           (sign_en),
        .scan_en           (scan_en),
        .dim_m             (dim_m),
        .dim_n             (dim_n),
        .elem_data         (elem_data),
        .write_en          (write_en),
        .data_ready        (data_ready),
        .user_id_a         (user_id_a),
        .user_id_b         (user_id_b),
        .user_input_valid  (user_input_valid),
        .config_valid      (config_valid),
        .config_type       (config_type),
        .config_value1     (config_value1),
        .config_value2     (config_value2)
    );

endmodule

// File: test/uart_cmd_parser_asserts.sv
`timescale 1ns/1ps

module uart_cmd_parser_asserts import uart_cmd_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      write_en,
    input logic      data_ready,
    input logic      user_input_valid,
    input logic      config_valid,
    input cfg_kind_t config_type
);

    int fail_count = 0;

    // each result strobe lasts a single cycle
    write_en_single: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |=> !write_en)
        else begin
            fail_count++;
            $error("write_en held for more than one cycle");
        end

    data_ready_single: assert property (@(posedge clk) disable iff (!rst_n)
        data_ready |=> !data_ready)
        else begin
            fail_count++;
            $error("data_ready held for more than one cycle");
        end

    ids_single: assert property (@(posedge clk) disable iff (!rst_n)
        user_input_valid |=> !user_input_valid)
        else begin
            fail_count++;
            $error("user_input_valid held for more than one cycle");
        end

    config_single: assert property (@(posedge clk) disable iff (!rst_n)
        config_valid |=> !config_valid)
        else begin
            fail_count++;
            $error("config_valid held for more than one cycle");
        end

    // completion never lands on an element write
    write_ready_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(write_en && data_ready))
        else begin
            fail_count++;
            $error("write_en and data_ready high together");
        end

    config_kind_legal: assert property (@(posedge clk) disable iff (!rst_n)
        config_valid |-> config_type inside {cfg_max, cfg_range, cfg_count, cfg_scalar})
        else begin
            fail_count++;
            $error("config_valid with an illegal config_type");
        end

endmodule

bind cmd_sequencer uart_cmd_parser_asserts u_asserts (
    .clk              (clk),
    .rst_n            (rst_n),
    .write_en         (write_en),
    .data_ready       (data_ready),
    .user_input_valid (user_input_valid),
    .config_valid     (config_valid),
    .config_type      (config_type)
);

// File: test/tb_uart_cmd_parser.sv
`timescale 1ns/1ps

module tb_uart_cmd_parser;

    localparam string data_path = "test/uart_cmd_testdata.txt";

    // pulse kinds held in the expectation queue
    localparam int ev_write  = 1;
    localparam int ev_ready  = 2;
    localparam int ev_ids    = 3;
    localparam int ev_config = 4;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [7:0]        rx_data;
    logic              rx_valid;
    logic [1:0]        mode_sel;
    logic              in_operand_select;
    logic [2:0]        dim_m;
    logic [2:0]        dim_n;
    logic [7:0]        elem_data;
    logic              write_en;
    logic              data_ready;
    logic [3:0]        user_id_a;
    logic [3:0]        user_id_b;
    logic              user_input_valid;
    logic              config_valid;
    logic [2:0]        config_type;
    logic signed [7:0] config_value1;
    logic signed [7:0] config_value2;

    int              exp_kind[$];
    int              exp_a[$];
    int              exp_b[$];
    int              exp_c[$];
    logic [31:0]     lfsr = 32'h6d5c_5723;
    logic [8*24-1:0] test_name;
    logic            test_open = 1'b0;
    int              errors = 0;
    int              test_err_start = 0;
    int              tests_ok = 0;
    int              tests_bad = 0;
    int              cycles = 0;
    int              cycle_limit = 0;

    uart_cmd_parser #(
        .dim_w (3),
        .id_w  (4)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .mode_sel          (mode_sel),
        .in_operand_select (in_operand_select),
        .dim_m             (dim_m),
        .dim_n             (dim_n),
        .elem_data         (elem_data),
        .write_en          (write_en),
        .data_ready        (data_ready),
        .user_id_a         (user_id_a),
        .user_id_b         (user_id_b),
        .user_input_valid  (user_input_valid),
        .config_valid      (config_valid),
        .config_type       (config_type),
        .config_value1     (config_value1),
        .config_value2     (config_value2)
    );

    always #2 clk = ~clk;

    // cycle limit comes from the byte count of the data file
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run hit the cycle limit of %0d before the tests finished", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        // taps 32 22 2 1
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic string pulse_name(input int k);
        case (k)
            ev_write:  return "write_en";
            ev_ready:  return "data_ready";
            ev_ids:    return "user_input_valid";
            ev_config: return "config_valid";
            default:   return "unknown";
        endcase
    endfunction

    task automatic report_value(input string sig, input int expected, input int actual);
        $display("ERROR %0d ns: %s expected %0d, actual %0d", $time, sig, expected, actual);
        errors++;
    endtask

    task automatic expect_event(input int kind, input int a, input int b, input int c);
        exp_kind.push_back(kind);
        exp_a.push_back(a);
        exp_b.push_back(b);
        exp_c.push_back(c);
    endtask

    task automatic take_pulse(input int kind);
        int k;
        int a;
        int b;
        int c;
        if (exp_kind.size() == 0) begin
            $display("unexpected %s pulse at %0d ns", pulse_name(kind), $time);
            errors++;
        end else begin
            k = exp_kind.pop_front();
            a = exp_a.pop_front();
            b = exp_b.pop_front();
            c = exp_c.pop_front();
            if (k != kind) begin
                $display("%s pulse at %0d ns came while a %s pulse was due",
                         pulse_name(kind), $time, pulse_name(k));
                errors++;
            end else begin
                case (kind)
                    ev_write: begin
                        if (elem_data !== a[7:0]) report_value("elem_data", a, int'(elem_data));
                    end
                    ev_ready: begin
                        if (dim_m !== a[2:0]) report_value("dim_m", a, int'(dim_m));
                        if (dim_n !== b[2:0]) report_value("dim_n", b, int'(dim_n));
                    end
                    ev_ids: begin
                        if (user_id_a !== a[3:0]) report_value("user_id_a", a, int'(user_id_a));
                        if (user_id_b !== b[3:0]) report_value("user_id_b", b, int'(user_id_b));
                    end
                    default: begin
                        if (config_type !== a[2:0]) begin
                            report_value("config_type", a, int'(config_type));
                        end
                        if (config_value1 !== b[7:0]) begin
                            report_value("config_value1", b, int'(config_value1));
                        end
                        // second value only means something for a range
                        if (a == 1 && config_value2 !== c[7:0]) begin
                            report_value("config_value2", c, int'(config_value2));
                        end
                    end
                endcase
            end
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (write_en) take_pulse(ev_write);
            if (data_ready) take_pulse(ev_ready);
            if (user_input_valid) take_pulse(ev_ids);
            if (config_valid) take_pulse(ev_config);
        end
    end

    // one byte with a single-cycle strobe, then a jittered gap of 4 to 7 cycles
    task automatic send_byte(input int ms, input int op, input logic [7:0] b);
        int gap;
        mode_sel          = ms[1:0];
        in_operand_select = op[0];
        rx_data           = b;
        rx_valid          = 1'b1;
        @(negedge clk);
        rx_valid          = 1'b0;
        in_operand_select = 1'b0;
        lfsr = lfsr_next(lfsr);
        gap  = 4 + int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        gap  = gap + 2 * int'(lfsr[0]);
        repeat (gap) @(negedge clk);
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (exp_kind.size() != 0 && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        // quiet window to catch stray pulses
        repeat (8) @(negedge clk);
        if (exp_kind.size() != 0) begin
            $display("test %0s: %0d expected pulses never came", test_name, exp_kind.size());
            errors++;
            exp_kind.delete();
            exp_a.delete();
            exp_b.delete();
            exp_c.delete();
        end
        if (errors == test_err_start) begin
            tests_ok++;
            $display("test %0s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %0s: failed with %0d errors", test_name, errors - test_err_start);
        end
    endtask

    task automatic count_bytes(input int fd, output int total);
        int rc;
        int ms;
        int op;
        int n;
        logic [7:0]      tag;
        logic [8*24-1:0] payload;
        logic [8*80-1:0] rest;
        total = 0;
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "S") begin
                rc = $fscanf(fd, "%d %d %d %h", ms, op, n, payload);
                total += n;
            end else begin
                rc = $fgets(rest, fd);
            end
        end
    endtask

    task automatic run_tests(input int fd);
        int rc;
        int ms;
        int op;
        int n;
        int a;
        int b;
        int c;
        logic [7:0]      tag;
        logic [8*24-1:0] payload;
        logic [8*80-1:0] rest;
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "T": begin
                    if (test_open) finish_test();
                    rc = $fscanf(fd, "%s", test_name);
                    test_open      = 1'b1;
                    test_err_start = errors;
                end
                "S": begin
                    rc = $fscanf(fd, "%d %d %d %h", ms, op, n, payload);
                    if (rc != 4 || n < 1 || n > 24) begin
                        $display("malformed send line in %s", data_path);
                        errors++;
                    end else begin
                        // first byte sits in the top of the payload
                        for (int i = 0; i < n; i++) begin
                            send_byte(ms, op, payload[8*(n-1-i) +: 8]);
                        end
                    end
                end
                "W": begin
                    rc = $fscanf(fd, "%d", a);
                    expect_event(ev_write, a, 0, 0);
                end
                "D": begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    expect_event(ev_ready, a, b, 0);
                end
                "O": begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    expect_event(ev_ids, a, b, 0);
                end
                "C": begin
                    rc = $fscanf(fd, "%d %d %d", a, b, c);
                    expect_event(ev_config, a, b, c);
                end
                default: rc = $fgets(rest, fd);
            endcase
        end
        if (test_open) finish_test();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int fd;
        int total;
        int assert_fails;
        rst_n             = 1'b0;
        rx_data           = 8'h00;
        rx_valid          = 1'b0;
        mode_sel          = 2'd0;
        in_operand_select = 1'b0;
        fd = $fopen(data_path, "r");
        if (fd == 0) begin
            $display("cannot open %s", data_path);
            errors++;
        end else begin
            count_bytes(fd, total);
            $fclose(fd);
            cycle_limit = total * 8 + 200;
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            fd = $fopen(data_path, "r");
            run_tests(fd);
            $fclose(fd);
        end
        assert_fails = dut.u_seq.u_asserts.fail_count;
        if (assert_fails > 0) begin
            $display("%0d assertion failures on the sequencer pulses", assert_fails);
            errors += assert_fails;
        end
        $display("summary: %0d tests ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: test/uart_cmd_testdata.txt
# T name | S mode_sel operand_flag byte_count hex_bytes | W element
# D m n | O id_a id_b | C kind value1 value2 ; expectations precede their bytes
T matrix_2x3
W 1
W 2
W 3
W 4
W 5
W 6
D 2 3
S 1 0 16 32203320312032203320342035203620
T wide_elem_spacing
W 200
W 7
D 1 2
S 1 0 12 31203220203230300d0a370a
T operand_select
O 3 12
S 0 1 5 3320313220
T config_single_value
C 0 5 0
S 0 0 13 434f4e464947204d4158203520
C 2 15 0
S 0 0 16 434f4e46494720434f554e5420313520
C 4 -5 0
S 0 0 17 434f4e464947205343414c4152202d3520
T config_range
C 1 -3 20
S 0 0 19 434f4e4649472052414e4745202d3320323020
T config_misspelled
S 0 0 13 434f4e464947204d415a203520

// File: build.f
hw/uart_cmd_pkg.sv
hw/decimal_accum.sv
hw/config_keyword_detect.sv
hw/cmd_sequencer.sv
hw/uart_cmd_parser.sv
test/uart_cmd_parser_asserts.sv
test/tb_uart_cmd_parser.sv

// File: Makefile
TOP := tb_uart_cmd_parser

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation ended early"; exit 1)

obj_dir/V$(TOP): build.f hw/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
